// File: source/mmio_defines.svh
/* MMIO bridge widths, queue depths, credit counts and tag count */

`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

`define MMIO_DATA_WIDTH      64
`define MMIO_ADDR_WIDTH      16
`define MMIO_INDEX_WIDTH     14   // Byte address without the two low bits
`define MMIO_TID_WIDTH       3
`define MMIO_TID_COUNT       (1 << `MMIO_TID_WIDTH)
`define MMIO_REQ_DEPTH_LOG2  3
`define MMIO_AFU_CREDITS     4
`define MMIO_CREDIT_WIDTH    3    // Holds the full accelerator credit count

// len, poison, tid, index from the top bit down
`define MMIO_HDR_WIDTH       (2 + 1 + `MMIO_TID_WIDTH + `MMIO_INDEX_WIDTH)

`endif

// File: source/mmio_field_pkg.sv
/* MMIO field types: byte addresses, word indices, read tags and data */

`default_nettype none

`include "mmio_defines.svh"

package mmio_field_pkg;

   // Software byte address
   typedef logic [`MMIO_ADDR_WIDTH-1:0] mmio_addr_t;

   // Index of a 32-bit word
   typedef logic [`MMIO_INDEX_WIDTH-1:0] mmio_index_t;

   // Read transaction tag
   typedef logic [`MMIO_TID_WIDTH-1:0] mmio_tid_t;

   typedef logic [`MMIO_DATA_WIDTH-1:0] mmio_data_t;  // Request and response data

endpackage

`default_nettype wire

// File: source/mmio_hdr_pkg.sv
/* MMIO header types: length code, packed config header, request queue entry */

`default_nettype none

`include "mmio_defines.svh"

package mmio_hdr_pkg;

   typedef logic [1:0] mmio_len_t;                     // 0 is 32-bit, 1 is 64-bit
   typedef logic [`MMIO_HDR_WIDTH-1:0] mmio_hdr_t;     // {len, poison, tid, index}

   // {is_write, is_read, hdr, data}
   typedef logic [2+`MMIO_HDR_WIDTH+`MMIO_DATA_WIDTH-1:0] mmio_entry_t;

endpackage

`default_nettype wire

// File: source/mmio_links.sv
/* Internal links of the MMIO bridge: encoder to request queue, encoder to tag pool */

`timescale 1ns/1ps
`default_nettype none

// One-cycle push of a built request, no back-pressure
interface mmio_entry_if;
   logic                      valid;
   logic                      is_write;
   logic                      is_read;
   mmio_hdr_pkg::mmio_hdr_t   hdr;
   mmio_field_pkg::mmio_data_t data;

   modport src (output valid, is_write, is_read, hdr, data);
   modport dst (input valid, is_write, is_read, hdr, data);
endinterface

// Pool offers its next free tag, user claims it with the word index
interface mmio_tag_alloc_if;
   logic                        alloc;
   mmio_field_pkg::mmio_tid_t   tid;
   mmio_field_pkg::mmio_index_t index;
   logic                        avail;

   modport user (output alloc, index, input tid, avail);
   modport pool (input alloc, index, output tid, avail);
endinterface

`default_nettype wire

// File: source/mmio_sync_fifo.sv
/* Synchronous FIFO, pointer based
   Popped entry lands in an output register with a valid flag the next cycle */

`timescale 1ns/1ps
`default_nettype none

module mmio_sync_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_LOG2 = 3
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             push,
   input  logic [WIDTH-1:0] din,
   input  logic             pop,
   output logic [WIDTH-1:0] dout,
   output logic             dout_valid,
   output logic             empty
);

   logic [WIDTH-1:0]    mem [2**DEPTH_LOG2];
   logic [DEPTH_LOG2:0] wr_ptr;   // Extra bit tells full from empty
   logic [DEPTH_LOG2:0] rd_ptr;
   logic                do_pop;

   assign empty  = (wr_ptr == rd_ptr);
   assign do_pop = pop & ~empty;   // Pop on empty is ignored

   // Storage and output register
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= din;
      end
      if (do_pop) begin
         dout <= mem[rd_ptr[DEPTH_LOG2-1:0]];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         dout_valid <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         dout_valid <= do_pop;   // Head shown for one cycle
      end
   end

endmodule

`default_nettype wire

// File: source/mmio_req_encoder.sv
/* Request encoder, turns software commands into config headers
   Reads claim a free tag from the tag table */

`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module mmio_req_encoder (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       sw_req_valid,
   input  logic                       sw_req_write,
   input  mmio_field_pkg::mmio_addr_t sw_req_addr,
   input  mmio_field_pkg::mmio_data_t sw_req_wdata,
   input  logic                       sw_req_wide,
   output logic                       sw_req_ready,
   mmio_entry_if.src                  entry,
   mmio_tag_alloc_if.user             tag
);

   logic                        active;   // Low through reset
   logic                        accept;
   mmio_field_pkg::mmio_index_t index;
   mmio_hdr_pkg::mmio_len_t     len;
   mmio_field_pkg::mmio_tid_t   tid;
   mmio_field_pkg::mmio_data_t  data_next;

   assign index        = sw_req_addr[`MMIO_ADDR_WIDTH-1:2];
   assign sw_req_ready = active & (sw_req_write | tag.avail);
   assign accept       = sw_req_valid & sw_req_ready;

   // Claim the offered tag in the accept cycle
   assign tag.alloc = accept & ~sw_req_write;
   assign tag.index = index;

   always_comb begin
      if (sw_req_write) begin
         len       = sw_req_wide ? 2'd1 : 2'd0;
         tid       = '0;
         data_next = sw_req_wide ? sw_req_wdata :
                     {{(`MMIO_DATA_WIDTH-32){1'b0}}, sw_req_wdata[31:0]};
      end else begin
         len       = 2'd1;   // Reads are always 64-bit
         tid       = tag.tid;
         data_next = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active      <= 1'b0;
         entry.valid <= 1'b0;
      end else begin
         active      <= 1'b1;
         entry.valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         entry.is_write <= sw_req_write;
         entry.is_read  <= ~sw_req_write;
         entry.hdr      <= {len, 1'b0, tid, index};   // Poison always clear
         entry.data     <= data_next;
      end
   end

endmodule

`default_nettype wire

// File: source/mmio_req_issue.sv
/* Request issue, queues encoded requests and sends them on accelerator credits
   Each send returns one queue slot to software */

`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module mmio_req_issue (
   input  logic                       clk,
   input  logic                       rst,
   mmio_entry_if.dst                  entry,
   input  logic                       afu_credit,
   output logic                       mmio_wrvalid,
   output logic                       mmio_rdvalid,
   output mmio_hdr_pkg::mmio_hdr_t    mmio_hdr,
   output mmio_field_pkg::mmio_data_t mmio_data,
   output logic                       sw_credit
);

   mmio_hdr_pkg::mmio_entry_t    q_din;
   mmio_hdr_pkg::mmio_entry_t    q_dout;
   logic                         q_valid;
   logic                         q_empty;
   logic                         q_pop;
   logic [`MMIO_CREDIT_WIDTH-1:0] credits;

   assign q_din = {entry.is_write, entry.is_read, entry.hdr, entry.data};
   assign q_pop = ~q_empty & (credits != '0);

   mmio_sync_fifo #(
      .WIDTH      ($bits(mmio_hdr_pkg::mmio_entry_t)),
      .DEPTH_LOG2 (`MMIO_REQ_DEPTH_LOG2)
   ) u_req_queue (
      .clk        (clk),
      .rst        (rst),
      .push       (entry.valid),
      .din        (q_din),
      .pop        (q_pop),
      .dout       (q_dout),
      .dout_valid (q_valid),
      .empty      (q_empty)
   );

   // Accelerator credits, spent at pop and returned by afu_credit
   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= `MMIO_CREDIT_WIDTH'(`MMIO_AFU_CREDITS);
      end else begin
         credits <= credits + `MMIO_CREDIT_WIDTH'(afu_credit)
                    - `MMIO_CREDIT_WIDTH'(q_pop);
      end
   end

   // Unpack the head entry
   assign mmio_wrvalid = q_valid & q_dout[$bits(q_dout)-1];
   assign mmio_rdvalid = q_valid & q_dout[$bits(q_dout)-2];
   assign mmio_hdr     = q_dout[`MMIO_DATA_WIDTH+`MMIO_HDR_WIDTH-1:`MMIO_DATA_WIDTH];
   assign mmio_data    = q_dout[`MMIO_DATA_WIDTH-1:0];
   assign sw_credit    = q_valid;   // Slot already left the queue

endmodule

`default_nettype wire

// File: source/mmio_tag_table.sv
/* Read tag table, tracks busy tags and the word index each one was issued for */

`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module mmio_tag_table (
   input  logic                        clk,
   input  logic                        rst,
   mmio_tag_alloc_if.pool              tag,
   input  mmio_field_pkg::mmio_tid_t   lookup_tid,
   output mmio_field_pkg::mmio_index_t lookup_index,
   input  logic                        tag_release
);

   logic [`MMIO_TID_COUNT-1:0]  busy;
   mmio_field_pkg::mmio_index_t index_mem [`MMIO_TID_COUNT];
   mmio_field_pkg::mmio_tid_t   free_tid;

   // Lowest free tag wins
   always_comb begin
      free_tid = '0;
      for (int i = `MMIO_TID_COUNT - 1; i >= 0; i--) begin
         if (!busy[i]) begin
            free_tid = mmio_field_pkg::mmio_tid_t'(i);
         end
      end
   end

   assign tag.tid      = free_tid;
   assign tag.avail    = ~&busy;
   assign lookup_index = index_mem[lookup_tid];

   // Alloc and release never hit the same tag
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= '0;
      end else begin
         if (tag_release) busy[lookup_tid] <= 1'b0;
         if (tag.alloc)   busy[tag.tid]    <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (tag.alloc) index_mem[tag.tid] <= tag.index;
   end

endmodule

`default_nettype wire

// File: source/mmio_rsp_collector.sv
/* Response collector, stages accelerator read data and maps tags back to addresses */

`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module mmio_rsp_collector (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        mmio_rspvalid,
   input  mmio_field_pkg::mmio_tid_t   mmio_rsptid,
   input  mmio_field_pkg::mmio_data_t  mmio_rspdata,
   output mmio_field_pkg::mmio_tid_t   lookup_tid,
   input  mmio_field_pkg::mmio_index_t lookup_index,
   output logic                        tag_release,
   output logic                        sw_rsp_valid,
   output mmio_field_pkg::mmio_addr_t  sw_rsp_addr,
   output mmio_field_pkg::mmio_data_t  sw_rsp_data
);

   logic [`MMIO_TID_WIDTH+`MMIO_DATA_WIDTH-1:0] rsp_dout;
   logic                                        rsp_valid;
   logic                                        rsp_empty;

   // One slot per tag, so staging never overflows
   mmio_sync_fifo #(
      .WIDTH      (`MMIO_TID_WIDTH + `MMIO_DATA_WIDTH),
      .DEPTH_LOG2 (`MMIO_TID_WIDTH)
   ) u_rsp_fifo (
      .clk        (clk),
      .rst        (rst),
      .push       (mmio_rspvalid),
      .din        ({mmio_rsptid, mmio_rspdata}),
      .pop        (~rsp_empty),
      .dout       (rsp_dout),
      .dout_valid (rsp_valid),
      .empty      (rsp_empty)
   );

   assign lookup_tid  = rsp_dout[`MMIO_TID_WIDTH+`MMIO_DATA_WIDTH-1:`MMIO_DATA_WIDTH];
   assign tag_release = rsp_valid;   // Tag frees as the response goes out

   always_ff @(posedge clk) begin
      if (rst) sw_rsp_valid <= 1'b0;
      else     sw_rsp_valid <= rsp_valid;
   end

   always_ff @(posedge clk) begin
      sw_rsp_addr <= {lookup_index, 2'b00};   // Word index back to byte address
      sw_rsp_data <= rsp_dout[`MMIO_DATA_WIDTH-1:0];
   end

endmodule

`default_nettype wire

// File: source/mmio_block.sv
/* MMIO bridge top, software config requests to accelerator and read data back */

`timescale 1ns/1ps
`default_nettype none

module mmio_block (
   input  logic                        clk,
   input  logic                        rst,
   // Software request side
   input  logic                        sw_req_valid,
   input  logic                        sw_req_write,
   input  mmio_field_pkg::mmio_addr_t  sw_req_addr,
   input  mmio_field_pkg::mmio_data_t  sw_req_wdata,
   input  logic                        sw_req_wide,
   output logic                        sw_req_ready,
   output logic                        sw_credit,
   // Software read return
   output logic                        sw_rsp_valid,
   output mmio_field_pkg::mmio_addr_t  sw_rsp_addr,
   output mmio_field_pkg::mmio_data_t  sw_rsp_data,
   // Accelerator requests
   output logic                        mmio_wrvalid,
   output logic                        mmio_rdvalid,
   output mmio_hdr_pkg::mmio_hdr_t     mmio_hdr,
   output mmio_field_pkg::mmio_data_t  mmio_data,
   input  logic                        afu_credit,
   // Accelerator read responses
   input  logic                        mmio_rspvalid,
   input  mmio_field_pkg::mmio_tid_t   mmio_rsptid,
   input  mmio_field_pkg::mmio_data_t  mmio_rspdata
);

   mmio_entry_if     entry_link ();
   mmio_tag_alloc_if tag_link ();

   mmio_field_pkg::mmio_tid_t   lookup_tid;
   mmio_field_pkg::mmio_index_t lookup_index;
   logic                        tag_release;

   mmio_req_encoder u_encoder (
      .clk, .rst, .sw_req_valid, .sw_req_write, .sw_req_addr, .sw_req_wdata,
      .sw_req_wide, .sw_req_ready,
      .entry (entry_link.src),
      .tag   (tag_link.user)
   );

   mmio_req_issue u_issue (
      .clk, .rst,
      .entry (entry_link.dst),
      .afu_credit, .mmio_wrvalid, .mmio_rdvalid, .mmio_hdr, .mmio_data, .sw_credit
   );

   mmio_tag_table u_tag_table (
      .clk, .rst,
      .tag (tag_link.pool),
      .lookup_tid, .lookup_index, .tag_release
   );

   mmio_rsp_collector u_collector (
      .clk, .rst, .mmio_rspvalid, .mmio_rsptid, .mmio_rspdata,
      .lookup_tid, .lookup_index, .tag_release,
      .sw_rsp_valid, .sw_rsp_addr, .sw_rsp_data
   );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
/* Testbench clock source, 100 ns period */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk
);

   initial clk = 1'b0;
   always #50 clk = ~clk;   // Half period

endmodule

`default_nettype wire

// File: bench/tb_mmio_block.sv
/* MMIO bridge testbench with software and accelerator models
   Checks encoding, ordering, credits, read tags and read returns */

`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module tb_mmio_block;

   localparam int MAX_CYCLES = 4000;   // About ten times the expected run
   localparam int NUM_WR     = 24;
   localparam int NUM_MIX    = 16;
   localparam int NUM_CMDS   = NUM_WR + NUM_MIX + 9;

   typedef struct packed {
      logic                       write;
      logic                       wide;
      mmio_field_pkg::mmio_addr_t addr;
      mmio_field_pkg::mmio_data_t wdata;
   } cmd_t;

   logic clk, rst;
   logic sw_req_valid, sw_req_write, sw_req_wide, sw_req_ready, sw_credit;
   mmio_field_pkg::mmio_addr_t  sw_req_addr, sw_rsp_addr;
   mmio_field_pkg::mmio_data_t  sw_req_wdata, sw_rsp_data, mmio_data, mmio_rspdata;
   logic sw_rsp_valid, mmio_wrvalid, mmio_rdvalid, afu_credit, mmio_rspvalid;
   mmio_hdr_pkg::mmio_hdr_t     mmio_hdr;
   mmio_field_pkg::mmio_tid_t   mmio_rsptid;

   int   seed = 32'hbbf0;
   int   rnd, pick, due_idx, cycle;
   int   mismatches, other_errors;
   int   sw_credits, sends, credits_back, outstanding;
   logic rsp_enable;
   cmd_t cmds [NUM_CMDS];
   cmd_t cur;
   cmd_t exp_q [$];                            // Accepted, not yet sent
   mmio_field_pkg::mmio_tid_t   pending_tid [$];   // Sent reads awaiting an answer
   mmio_field_pkg::mmio_tid_t   rsp_order [$];     // Answers in return order
   mmio_field_pkg::mmio_tid_t   mon_tid, rsp_tid;
   int   credit_due [$];
   logic [`MMIO_TID_COUNT-1:0]  tag_busy;
   mmio_field_pkg::mmio_index_t tag_index [`MMIO_TID_COUNT];

   tb_clock_gen u_clock (.clk(clk));

   mmio_block DUT (
      .clk, .rst, .sw_req_valid, .sw_req_write, .sw_req_addr, .sw_req_wdata,
      .sw_req_wide, .sw_req_ready, .sw_credit, .sw_rsp_valid, .sw_rsp_addr,
      .sw_rsp_data, .mmio_wrvalid, .mmio_rdvalid, .mmio_hdr, .mmio_data,
      .afu_credit, .mmio_rspvalid, .mmio_rsptid, .mmio_rspdata
   );

   // Read data pattern the accelerator holds at each word
   function automatic mmio_field_pkg::mmio_data_t expected_rd_data(
      input mmio_field_pkg::mmio_index_t index);
      logic [31:0] word;
      word = 32'(index);
      return {word ^ 32'hc0de_5a5a, (word * 32'h9e37_79b9) + 32'h1234};
   endfunction

   function automatic mmio_hdr_pkg::mmio_hdr_t expected_hdr(input cmd_t cmd,
      input mmio_field_pkg::mmio_tid_t tid);
      mmio_hdr_pkg::mmio_len_t   len;
      mmio_field_pkg::mmio_tid_t hdr_tid;
      len     = (cmd.write && !cmd.wide) ? 2'd0 : 2'd1;   // Reads are 64-bit
      hdr_tid = cmd.write ? '0 : tid;
      return {len, 1'b0, hdr_tid, cmd.addr[`MMIO_ADDR_WIDTH-1:2]};
   endfunction

   function automatic mmio_field_pkg::mmio_data_t expected_data(input cmd_t cmd);
      if (!cmd.write) return '0;
      if (cmd.wide) return cmd.wdata;
      return {32'h0, cmd.wdata[31:0]};
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
      input logic [63:0] expected);
      if (actual !== expected) begin
         mismatches++;
         $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   task automatic report_and_finish();
      $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   endtask

   // Holds the request until the bridge is ready, one credit per request
   task automatic send_request(input cmd_t cmd);
      while (sw_credits == 0) @(negedge clk);
      @(posedge clk);
      sw_req_valid <= 1'b1;
      sw_req_write <= cmd.write;
      sw_req_addr  <= cmd.addr;
      sw_req_wdata <= cmd.wdata;
      sw_req_wide  <= cmd.wide;
      @(negedge clk);
      while (!sw_req_ready) @(negedge clk);
      @(posedge clk);   // Accepted at this edge
      sw_req_valid <= 1'b0;
      sw_credits--;
      exp_q.push_back(cmd);
      if (!cmd.write) outstanding++;
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0 || outstanding != 0) @(negedge clk);
   endtask

   initial begin
      rst = 1'b1;
      sw_req_valid = 1'b0;
      sw_req_write = 1'b0;
      sw_req_addr  = '0;
      sw_req_wdata = '0;
      sw_req_wide  = 1'b0;
      sw_credits   = 1 << `MMIO_REQ_DEPTH_LOG2;
      rsp_enable   = 1'b1;
      for (int i = 0; i < NUM_CMDS; i++) begin
         rnd = $random(seed);
         cmds[i].wide  = rnd[0];
         cmds[i].write = (i < NUM_WR) ? 1'b1 : (i < NUM_WR + NUM_MIX) ? rnd[1] : 1'b0;
         cmds[i].addr  = 16'($random(seed));
         cmds[i].wdata = {32'($random(seed)), 32'($random(seed))};
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < NUM_WR + NUM_MIX; i++) send_request(cmds[i]);
      wait_idle();
      // Fill all tags with answers held back
      rsp_enable = 1'b0;
      for (int i = NUM_WR + NUM_MIX; i < NUM_CMDS - 1; i++) send_request(cmds[i]);
      while (pending_tid.size() < `MMIO_TID_COUNT) @(negedge clk);
      check_value("sw_req_ready", 64'(sw_req_ready), 64'(0));
      rsp_enable = 1'b1;
      send_request(cmds[NUM_CMDS-1]);   // Needs a freed tag
      wait_idle();
      repeat (10) @(posedge clk);
      check_value("sw_credits", 64'(sw_credits), 64'(1 << `MMIO_REQ_DEPTH_LOG2));
      report_and_finish();
   end

   // Accelerator model, credit return and shuffled read answers
   initial begin
      afu_credit    = 1'b0;
      mmio_rspvalid = 1'b0;
      mmio_rsptid   = '0;
      mmio_rspdata  = '0;
      forever begin
         @(posedge clk);
         foreach (credit_due[i]) if (credit_due[i] > 0) credit_due[i]--;
         due_idx = -1;
         foreach (credit_due[i]) if (due_idx < 0 && credit_due[i] == 0) due_idx = i;
         if (due_idx >= 0) credit_due.delete(due_idx);
         afu_credit <= (due_idx >= 0);
         rnd = $random(seed);
         if (rsp_enable && pending_tid.size() != 0 && rnd[0]) begin
            pick    = int'($unsigned($random(seed)) % pending_tid.size());
            rsp_tid = pending_tid[pick];
            pending_tid.delete(pick);
            rsp_order.push_back(rsp_tid);
            mmio_rspvalid <= 1'b1;
            mmio_rsptid   <= rsp_tid;
            mmio_rspdata  <= expected_rd_data(tag_index[rsp_tid]);
         end else begin
            mmio_rspvalid <= 1'b0;
         end
      end
   end

   // Compare process, samples between edges
   initial begin
      tag_busy = '0;
      forever begin
         @(negedge clk);
         if (!rst) begin
            check_value("sw_credit", 64'(sw_credit), 64'(mmio_wrvalid | mmio_rdvalid));
            if (mmio_wrvalid || mmio_rdvalid) begin
               sends++;
               if (sends > `MMIO_AFU_CREDITS + credits_back) begin
                  other_errors++;
                  $display("error: request %0d sent without an accelerator credit", sends);
               end
               if (exp_q.size() == 0) begin
                  other_errors++;
                  $display("error: request sent that software never issued");
               end else begin
                  cur     = exp_q.pop_front();
                  mon_tid = mmio_hdr[`MMIO_INDEX_WIDTH +: `MMIO_TID_WIDTH];
                  check_value("mmio_wrvalid", 64'(mmio_wrvalid), 64'(cur.write));
                  check_value("mmio_rdvalid", 64'(mmio_rdvalid), 64'(!cur.write));
                  check_value("mmio_hdr", 64'(mmio_hdr), 64'(expected_hdr(cur, mon_tid)));
                  check_value("mmio_data", mmio_data, expected_data(cur));
                  if (!cur.write) begin
                     if (tag_busy[mon_tid]) begin
                        other_errors++;
                        $display("error: read tag %0d reused while outstanding", mon_tid);
                     end
                     tag_busy[mon_tid]  = 1'b1;
                     tag_index[mon_tid] = cur.addr[`MMIO_ADDR_WIDTH-1:2];
                     pending_tid.push_back(mon_tid);
                  end
               end
               credit_due.push_back(1 + int'($unsigned($random(seed)) % 4));
            end
            if (afu_credit) credits_back++;
            if (sw_credit) sw_credits++;
            if (sw_rsp_valid) begin
               if (rsp_order.size() == 0) begin
                  other_errors++;
                  $display("error: read data returned with no answer pending");
               end else begin
                  rsp_tid = rsp_order.pop_front();
                  check_value("sw_rsp_addr", 64'(sw_rsp_addr), 64'({tag_index[rsp_tid], 2'b00}));
                  check_value("sw_rsp_data", sw_rsp_data, expected_rd_data(tag_index[rsp_tid]));
                  tag_busy[rsp_tid] = 1'b0;
                  outstanding--;
               end
            end
         end
      end
   end

   // Cycle limit
   initial begin
      cycle = 0;
      while (cycle < MAX_CYCLES) begin
         @(posedge clk);
         cycle++;
      end
      other_errors++;
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      report_and_finish();
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/mmio_field_pkg.sv
source/mmio_hdr_pkg.sv
source/mmio_links.sv
source/mmio_sync_fifo.sv
source/mmio_req_encoder.sv
source/mmio_req_issue.sv
source/mmio_tag_table.sv
source/mmio_rsp_collector.sv
source/mmio_block.sv
bench/tb_clock_gen.sv
bench/tb_mmio_block.sv

// File: run.sh
#!/bin/sh
# Build and run the MMIO bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_mmio_block -f flist.f

output=$(./obj_dir/Vtb_mmio_block)
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1
